/* Bender.yml */
package:
  name: acpi

sources:
  - verilog/acpi_pkg.sv
  - verilog/apb_reg_pkg.sv
  - verilog/acpi_regs.sv
  - verilog/window_fetch.sv
  - verilog/green_interp.sv
  - verilog/acpi_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/acpi_chk.sv
      - test/acpi_tb.sv

/* build.f */
verilog/acpi_pkg.sv
verilog/apb_reg_pkg.sv
verilog/acpi_regs.sv
verilog/window_fetch.sv
verilog/green_interp.sv
verilog/acpi_top.sv
test/tb_clock.sv
test/acpi_chk.sv
test/acpi_tb.sv

/* test/acpi_chk.sv */
`timescale 1ns/1ps

module acpi_chk #(
	parameter int IMG_W = 8,
	parameter int IMG_H = 8
) (
	input logic                        clk,
	input logic                        rst,
	input logic                        img_req,
	input logic                        img_ready,
	input logic [acpi_pkg::ADDR_W-1:0] img_addr,
	input logic                        finish,
	input logic                        out_valid,
	input acpi_pkg::pixel_t            out_data
);

	// Request must hold its address through a stall
	addr_stable: assert property (@(posedge clk) disable iff (rst)
		img_req && !img_ready |=> $stable(img_addr))
		else $error("img_addr changed while a read was stalled");

	addr_range: assert property (@(posedge clk) disable iff (rst)
		img_req |-> (img_addr < IMG_W * IMG_H))
		else $error("img_addr points outside the image");

	finish_pulse: assert property (@(posedge clk) disable iff (rst)
		finish |=> !finish)
		else $error("finish stayed high for more than one cycle");

	data_known: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !$isunknown(out_data))
		else $error("out_data has unknown bits on a valid beat");

endmodule

bind acpi_top acpi_chk #(
	.IMG_W (IMG_W),
	.IMG_H (IMG_H)
) i_chk (
	.clk       (clk),
	.rst       (rst),
	.img_req   (img_req),
	.img_ready (img_ready),
	.img_addr  (img_addr),
	.finish    (finish),
	.out_valid (out_valid),
	.out_data  (out_data)
);

/* test/acpi_tb.sv */
`timescale 1ns/1ps

module acpi_tb;

	localparam int IMG_W = 8;
	localparam int IMG_H = 8;
	localparam int NPIX  = IMG_W * IMG_H;
	// Six frames of 64 x 9 reads at about 2.4 cycles each is near 8500 cycles
	localparam int MAX_CYCLES = 20000;
	localparam logic [31:0] BUSY_VAL = 32'(1) << apb_reg_pkg::ST_BUSY;
	localparam logic [31:0] DONE_VAL = 32'(1) << apb_reg_pkg::ST_DONE;

	logic                           clk;
	logic                           rst;
	logic [apb_reg_pkg::APB_AW-1:0] paddr;
	logic                           psel;
	logic                           penable;
	logic                           pwrite;
	logic [31:0]                    pwdata;
	logic [31:0]                    prdata;
	logic                           pready;
	logic                           pslverr;
	logic                           img_ready;
	acpi_pkg::pixel_t               img_data;
	logic                           img_req;
	logic [acpi_pkg::ADDR_W-1:0]    img_addr;
	logic                           out_valid;
	logic [acpi_pkg::ADDR_W-1:0]    out_addr;
	acpi_pkg::pixel_t               out_data;
	logic                           finish;

	acpi_pkg::pixel_t image_mem [NPIX];
	int               exp_green [NPIX];
	int               beat_addr [$];
	int               beat_data [$];
	int               finish_count = 0;
	int               finish_mark = 0;
	int               beats_at_finish = 0;
	logic             finish_on_beat = 1'b0;
	logic             stall_en;
	logic [31:0]      fill_seed = 32'h9f2b;
	logic [31:0]      stall_seed = 32'h9f2b;
	int               cycle_count = 0;
	int               checks = 0;
	int               errors = 0;
	string            cur_test = "reset";

	tb_clock #(.PERIOD_NS(4.0)) i_clock (.clk(clk));

	acpi_top #(
		.IMG_W (IMG_W),
		.IMG_H (IMG_H)
	) i_dut (
		.clk       (clk),
		.rst       (rst),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.img_ready (img_ready),
		.img_data  (img_data),
		.img_req   (img_req),
		.img_addr  (img_addr),
		.out_valid (out_valid),
		.out_addr  (out_addr),
		.out_data  (out_data),
		.finish    (finish)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Border handling, -1 -> 1, -2 -> 2, N -> N-2, N+1 -> N-3
	function automatic int reflect(input int idx, input int n);
		if (idx == -1) begin
			return 1;
		end else if (idx == -2) begin
			return 2;
		end else if (idx == n) begin
			return n - 2;
		end else if (idx == n + 1) begin
			return n - 3;
		end
		return idx;
	endfunction

	function automatic int pix_at(input int r, input int c);
		return image_mem[reflect(r, IMG_H) * IMG_W + reflect(c, IMG_W)];
	endfunction

	function automatic int abs_int(input int v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic int floor_div(input int num, input int den);
		int q;
		q = num / den;
		if ((num % den != 0) && (num < 0)) begin
			q = q - 1;   // Round toward minus infinity
		end
		return q;
	endfunction

	// Expected green plane from the interpolation rules
	task automatic compute_expected();
		int c;
		int gh;
		int gv;
		int nh;
		int nv;
		int est;
		for (int r = 0; r < IMG_H; r++) begin
			for (int k = 0; k < IMG_W; k++) begin
				c = pix_at(r, k);
				if ((r + k) % 2 == 0) begin
					exp_green[r * IMG_W + k] = c;
				end else begin
					gh = abs_int(pix_at(r, k - 1) - pix_at(r, k + 1)) +
					     abs_int(2 * c - pix_at(r, k - 2) - pix_at(r, k + 2));
					gv = abs_int(pix_at(r - 1, k) - pix_at(r + 1, k)) +
					     abs_int(2 * c - pix_at(r - 2, k) - pix_at(r + 2, k));
					nh = 2 * (pix_at(r, k - 1) + pix_at(r, k + 1)) + 2 * c -
					     pix_at(r, k - 2) - pix_at(r, k + 2);
					nv = 2 * (pix_at(r - 1, k) + pix_at(r + 1, k)) + 2 * c -
					     pix_at(r - 2, k) - pix_at(r + 2, k);
					if (gh < gv) begin
						est = floor_div(nh, 4);
					end else if (gv < gh) begin
						est = floor_div(nv, 4);
					end else begin
						est = floor_div(nh + nv, 8);
					end
					exp_green[r * IMG_W + k] = (est < 0) ? 0 : ((est > 255) ? 255 : est);
				end
			end
		end
	endtask

	task automatic compare_value(input string what, input int exp, input int got);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("Mismatch in %s: %s expected %0d, actual %0d", cur_test, what, exp, got);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Error in %s: %s", cur_test, what);
		end
	endtask

	task automatic apb_transfer(input logic wr, input logic [apb_reg_pkg::APB_AW-1:0] addr,
	                            input logic [31:0] wdata, output logic [31:0] rdata,
	                            output logic err);
		@(posedge clk);   // Setup phase
		paddr   <= addr;
		pwrite  <= wr;
		pwdata  <= wdata;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);   // Access ends here, no wait states
		rdata = prdata;
		err   = pslverr;
		expect_true(pready, "pready was low in the access phase");
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_status(input logic [31:0] exp, input string what);
		logic [31:0] rd;
		logic        err;
		apb_transfer(1'b0, apb_reg_pkg::STATUS, 32'd0, rd, err);
		compare_value(what, exp, rd);
		compare_value({what, " pslverr"}, 0, err);
	endtask

	task automatic start_frame();
		logic [31:0] rd;
		logic        err;
		finish_mark = finish_count;
		beat_addr.delete();
		beat_data.delete();
		apb_transfer(1'b1, apb_reg_pkg::CTRL, 32'd1, rd, err);
		compare_value("CTRL write pslverr", 0, err);
	endtask

	task automatic wait_frame_end();
		while (finish_count == finish_mark) begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk);   // Catch any stray beats
	endtask

	task automatic verify_frame();
		compare_value("beat count", NPIX, beat_addr.size());
		compare_value("beats at finish", NPIX, beats_at_finish);
		expect_true(finish_on_beat, "finish did not come with the last output beat");
		for (int i = 0; i < beat_addr.size() && i < NPIX; i++) begin
			compare_value($sformatf("address of beat %0d", i), i, beat_addr[i]);
			compare_value($sformatf("data at %0d", i), exp_green[i], beat_data[i]);
		end
	endtask

	task automatic fill_random();
		for (int i = 0; i < NPIX; i++) begin
			fill_seed = lcg_step(fill_seed);
			image_mem[i] = fill_seed[23:16];
		end
	endtask

	// Greens 200, same-color sites alternate 255 and 0 in both directions
	task automatic fill_clamp(input logic invert);
		int r;
		int c;
		int v;
		for (int i = 0; i < NPIX; i++) begin
			r = i / IMG_W;
			c = i % IMG_W;
			if ((r + c) % 2 == 0) begin
				v = 200;
			end else begin
				v = ((r / 2 + c / 2) % 2 == 0) ? 255 : 0;
			end
			image_mem[i] = invert ? 8'(255 - v) : 8'(v);
		end
	endtask

	task automatic register_access();
		logic [31:0] rd;
		logic        err;
		cur_test = "register_access";
		read_status(32'd0, "STATUS after reset");
		apb_transfer(1'b0, apb_reg_pkg::CTRL, 32'd0, rd, err);
		compare_value("CTRL readback", 0, rd);
		compare_value("CTRL pslverr", 0, err);
		apb_transfer(1'b0, 4'h8, 32'd0, rd, err);
		compare_value("pslverr on read at 0x8", 1, err);
		apb_transfer(1'b1, 4'h8, 32'd1, rd, err);
		compare_value("pslverr on write at 0x8", 1, err);
	endtask

	task automatic flat_image();
		cur_test = "flat_image";
		stall_en = 1'b0;
		for (int i = 0; i < NPIX; i++) begin
			image_mem[i] = 8'd100;
			exp_green[i] = 100;
		end
		start_frame();
		wait_frame_end();
		verify_frame();
	endtask

	task automatic random_image();
		cur_test = "random_image";
		stall_en = 1'b1;
		fill_random();
		compute_expected();
		start_frame();
		wait_frame_end();
		verify_frame();
	endtask

	task automatic clamp_images();
		int n_hi;
		int n_lo;
		stall_en = 1'b1;
		for (int inv = 0; inv < 2; inv++) begin
			cur_test = (inv == 0) ? "clamp_high" : "clamp_low";
			fill_clamp(inv[0]);
			compute_expected();
			start_frame();
			wait_frame_end();
			verify_frame();
			n_hi = 0;
			n_lo = 0;
			foreach (beat_data[i]) begin
				n_hi += (beat_data[i] == 255);
				n_lo += (beat_data[i] == 0);
			end
			// Only the plain image reaches 255, only the inverted one reaches 0
			if (inv == 0) begin
				expect_true(n_hi > 0, "no output was clamped to 255");
			end else begin
				expect_true(n_lo > 0, "no output was clamped to 0");
			end
		end
	endtask

	task automatic status_and_restart();
		logic [31:0] rd;
		logic        err;
		cur_test = "status_and_restart";
		stall_en = 1'b1;
		fill_random();
		compute_expected();
		start_frame();
		read_status(BUSY_VAL, "STATUS during frame");
		apb_transfer(1'b1, apb_reg_pkg::CTRL, 32'd1, rd, err);   // Must be ignored
		wait_frame_end();
		read_status(DONE_VAL, "STATUS after finish");
		verify_frame();
		start_frame();
		read_status(BUSY_VAL, "STATUS after restart");
		wait_frame_end();
		verify_frame();
	endtask

	// Image memory answers a cycle after the request unless a stall is drawn
	always @(posedge clk) begin
		if (rst) begin
			img_ready <= 1'b0;
		end else if (img_req && !img_ready) begin
			stall_seed = lcg_step(stall_seed);
			if (stall_en && stall_seed[17:16] == 2'd0) begin
				img_ready <= 1'b0;
			end else begin
				img_ready <= 1'b1;
				img_data  <= image_mem[img_addr];
			end
		end else begin
			img_ready <= 1'b0;
		end
	end

	// Output stream monitor
	always @(posedge clk) begin
		if (out_valid) begin
			beat_addr.push_back(int'(out_addr));
			beat_data.push_back(int'(out_data));
		end
		if (finish) begin
			finish_on_beat  = out_valid;
			beats_at_finish = beat_addr.size();
			finish_count++;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout in %s after %0d cycles", cur_test, MAX_CYCLES);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		rst       = 1'b1;
		paddr     = '0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		pwdata    = '0;
		img_ready = 1'b0;
		img_data  = '0;
		stall_en  = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		register_access();
		flat_image();
		random_image();
		clamp_images();
		status_and_restart();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;   // Free running
	end

endmodule

/* verilog/acpi_pkg.sv */
package acpi_pkg;

	// One Bayer sample
	typedef logic [7:0] pixel_t;

	// Default frame size, overridden from the top level
	localparam int DEF_IMG_W = 128;
	localparam int DEF_IMG_H = 128;

	localparam int ADDR_W = 14;   // Pixel address width

	typedef enum logic [1:0] {
		IDLE,
		READ,
		EMIT
	} fetch_state_e;

	// Cross window taps, listed in the order they are read
	typedef enum logic [3:0] {
		CENTER,
		L1,
		L2,
		R1,
		R2,
		U1,
		U2,
		D1,
		D2
	} tap_e;

endpackage

/* verilog/acpi_regs.sv */
`timescale 1ns/1ps

module acpi_regs (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [apb_reg_pkg::APB_AW-1:0] paddr,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [31:0]                    pwdata,
	input  logic                           frame_done,
	output logic [31:0]                    prdata,
	output logic                           pready,
	output logic                           pslverr,
	output logic                           start
);

	logic access;     // APB access phase
	logic addr_ok;
	logic wr_ctrl;
	logic busy;
	logic done;

	assign access  = psel & penable;
	assign addr_ok = (paddr == apb_reg_pkg::CTRL) || (paddr == apb_reg_pkg::STATUS);
	assign wr_ctrl = access & pwrite & (paddr == apb_reg_pkg::CTRL);

	// No wait states
	assign pready  = 1'b1;
	assign pslverr = access & ~addr_ok;

	// CTRL reads back as zero
	always_comb begin
		prdata = '0;
		if (paddr == apb_reg_pkg::STATUS) begin
			prdata[apb_reg_pkg::ST_BUSY] = busy;
			prdata[apb_reg_pkg::ST_DONE] = done;
		end
	end

	// Start pulse, only taken while the fetcher is idle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			start <= 1'b0;
		end else begin
			start <= wr_ctrl & pwdata[0] & ~busy;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
			done <= 1'b0;   // New frame clears the old result
		end else if (frame_done) begin
			busy <= 1'b0;
			done <= 1'b1;
		end
	end

endmodule

/* verilog/acpi_top.sv */
`timescale 1ns/1ps

module acpi_top #(
	parameter int IMG_W = acpi_pkg::DEF_IMG_W,
	parameter int IMG_H = acpi_pkg::DEF_IMG_H
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [apb_reg_pkg::APB_AW-1:0] paddr,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [31:0]                    pwdata,
	output logic [31:0]                    prdata,
	output logic                           pready,
	output logic                           pslverr,
	input  logic                           img_ready,
	input  acpi_pkg::pixel_t               img_data,
	output logic                           img_req,
	output logic [acpi_pkg::ADDR_W-1:0]    img_addr,
	output logic                           out_valid,
	output logic [acpi_pkg::ADDR_W-1:0]    out_addr,
	output acpi_pkg::pixel_t               out_data,
	output logic                           finish
);

	logic                        start;
	logic                        win_valid;
	logic [acpi_pkg::ADDR_W-1:0] win_row;
	logic [acpi_pkg::ADDR_W-1:0] win_col;
	acpi_pkg::pixel_t            win_c;
	acpi_pkg::pixel_t            win_l1;
	acpi_pkg::pixel_t            win_l2;
	acpi_pkg::pixel_t            win_r1;
	acpi_pkg::pixel_t            win_r2;
	acpi_pkg::pixel_t            win_u1;
	acpi_pkg::pixel_t            win_u2;
	acpi_pkg::pixel_t            win_d1;
	acpi_pkg::pixel_t            win_d2;

	// finish doubles as the frame end strobe into the register block
	acpi_regs i_regs (
		.clk        (clk),
		.rst        (rst),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.frame_done (finish),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.start      (start)
	);

	window_fetch #(
		.IMG_W (IMG_W),
		.IMG_H (IMG_H)
	) i_fetch (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.img_ready  (img_ready),
		.img_data   (img_data),
		.img_req    (img_req),
		.img_addr   (img_addr),
		.win_valid  (win_valid),
		.win_row    (win_row),
		.win_col    (win_col),
		.win_c      (win_c),
		.win_l1     (win_l1),
		.win_l2     (win_l2),
		.win_r1     (win_r1),
		.win_r2     (win_r2),
		.win_u1     (win_u1),
		.win_u2     (win_u2),
		.win_d1     (win_d1),
		.win_d2     (win_d2),
		.frame_done (finish)
	);

	green_interp #(
		.IMG_W (IMG_W)
	) i_interp (
		.clk       (clk),
		.rst       (rst),
		.win_valid (win_valid),
		.win_row   (win_row),
		.win_col   (win_col),
		.win_c     (win_c),
		.win_l1    (win_l1),
		.win_l2    (win_l2),
		.win_r1    (win_r1),
		.win_r2    (win_r2),
		.win_u1    (win_u1),
		.win_u2    (win_u2),
		.win_d1    (win_d1),
		.win_d2    (win_d2),
		.out_valid (out_valid),
		.out_addr  (out_addr),
		.out_data  (out_data)
	);

endmodule

/* verilog/apb_reg_pkg.sv */
package apb_reg_pkg;

	localparam int APB_AW = 4;

	// Register offsets
	typedef enum logic [APB_AW-1:0] {
		CTRL   = 4'h0,   // Bit 0 starts a frame
		STATUS = 4'h4
	} reg_addr_e;

	// STATUS bit positions
	localparam int ST_BUSY = 0;
	localparam int ST_DONE = 1;

endpackage

/* verilog/green_interp.sv */
`timescale 1ns/1ps

module green_interp #(
	parameter int IMG_W = 128
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        win_valid,
	input  logic [acpi_pkg::ADDR_W-1:0] win_row,
	input  logic [acpi_pkg::ADDR_W-1:0] win_col,
	input  acpi_pkg::pixel_t            win_c,
	input  acpi_pkg::pixel_t            win_l1,
	input  acpi_pkg::pixel_t            win_l2,
	input  acpi_pkg::pixel_t            win_r1,
	input  acpi_pkg::pixel_t            win_r2,
	input  acpi_pkg::pixel_t            win_u1,
	input  acpi_pkg::pixel_t            win_u2,
	input  acpi_pkg::pixel_t            win_d1,
	input  acpi_pkg::pixel_t            win_d2,
	output logic                        out_valid,
	output logic [acpi_pkg::ADDR_W-1:0] out_addr,
	output acpi_pkg::pixel_t            out_data
);

	logic               green_site;
	logic [9:0]         grad_h;
	logic [9:0]         grad_v;
	logic signed [11:0] num_h;
	logic signed [11:0] num_v;
	logic signed [12:0] est;
	acpi_pkg::pixel_t   result;

	// |G1-G2| + |2C-C1-C2|
	function automatic logic [9:0] gradient(input acpi_pkg::pixel_t g1, g2, c, c1, c2);
		logic signed [10:0] dg;
		logic signed [10:0] dcc;
		logic signed [10:0] mag_g;
		logic signed [10:0] mag_c;
		dg    = $signed({3'b0, g1}) - $signed({3'b0, g2});
		dcc   = $signed({2'b0, c, 1'b0}) - $signed({3'b0, c1}) - $signed({3'b0, c2});
		mag_g = dg[10] ? -dg : dg;
		mag_c = dcc[10] ? -dcc : dcc;
		return mag_g[9:0] + mag_c[9:0];
	endfunction

	// 2(G1+G2) + 2C - C1 - C2, still to be divided
	function automatic logic signed [11:0] numerator(input acpi_pkg::pixel_t g1, g2, c, c1, c2);
		logic signed [11:0] gsum;
		gsum = $signed({3'b0, g1, 1'b0}) + $signed({3'b0, g2, 1'b0});
		return gsum + $signed({3'b0, c, 1'b0}) - $signed({4'b0, c1}) - $signed({4'b0, c2});
	endfunction

	assign green_site = ~(win_row[0] ^ win_col[0]);   // r+c even

	always_comb begin
		grad_h = gradient(win_l1, win_r1, win_c, win_l2, win_r2);
		grad_v = gradient(win_u1, win_d1, win_c, win_u2, win_d2);
		num_h  = numerator(win_l1, win_r1, win_c, win_l2, win_r2);
		num_v  = numerator(win_u1, win_d1, win_c, win_u2, win_d2);
		if (grad_h < grad_v) begin
			est = num_h >>> 2;
		end else if (grad_v < grad_h) begin
			est = num_v >>> 2;
		end else begin
			est = (num_h + num_v) >>> 3;   // Tie averages both directions
		end
		if (green_site) begin
			result = win_c;
		end else if (est < 0) begin
			result = 8'd0;
		end else if (est > 13'sd255) begin
			result = 8'd255;
		end else begin
			result = est[7:0];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= win_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid) begin
			out_addr <= acpi_pkg::ADDR_W'(win_row * IMG_W + win_col);
			out_data <= result;
		end
	end

endmodule

/* verilog/window_fetch.sv */
`timescale 1ns/1ps

module window_fetch #(
	parameter int IMG_W = 128,
	parameter int IMG_H = 128
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        start,
	input  logic                        img_ready,
	input  acpi_pkg::pixel_t            img_data,
	output logic                        img_req,
	output logic [acpi_pkg::ADDR_W-1:0] img_addr,
	output logic                        win_valid,
	output logic [acpi_pkg::ADDR_W-1:0] win_row,
	output logic [acpi_pkg::ADDR_W-1:0] win_col,
	output acpi_pkg::pixel_t            win_c,
	output acpi_pkg::pixel_t            win_l1,
	output acpi_pkg::pixel_t            win_l2,
	output acpi_pkg::pixel_t            win_r1,
	output acpi_pkg::pixel_t            win_r2,
	output acpi_pkg::pixel_t            win_u1,
	output acpi_pkg::pixel_t            win_u2,
	output acpi_pkg::pixel_t            win_d1,
	output acpi_pkg::pixel_t            win_d2,
	output logic                        frame_done
);

	acpi_pkg::fetch_state_e      state;
	acpi_pkg::tap_e              tap;
	logic [acpi_pkg::ADDR_W-1:0] row;
	logic [acpi_pkg::ADDR_W-1:0] col;
	acpi_pkg::pixel_t            taps [9];   // Filled in tap_e order
	int                          dr;
	int                          dc;
	int                          tap_row;
	int                          tap_col;
	logic                        last_pix;

	// Reflect an index that falls outside 0..n-1 back into the image
	function automatic int mirror(input int idx, input int n);
		if (idx < 0) begin
			return -idx;
		end else if (idx >= n) begin
			return 2 * n - 2 - idx;
		end
		return idx;
	endfunction

	// Offset of the tap being read
	always_comb begin
		dr = 0;
		dc = 0;
		case (tap)
			acpi_pkg::L1: dc = -1;
			acpi_pkg::L2: dc = -2;
			acpi_pkg::R1: dc = 1;
			acpi_pkg::R2: dc = 2;
			acpi_pkg::U1: dr = -1;
			acpi_pkg::U2: dr = -2;
			acpi_pkg::D1: dr = 1;
			acpi_pkg::D2: dr = 2;
			default: ;   // Center
		endcase
		tap_row  = mirror(int'(row) + dr, IMG_H);
		tap_col  = mirror(int'(col) + dc, IMG_W);
		img_addr = acpi_pkg::ADDR_W'(tap_row * IMG_W + tap_col);
	end

	assign img_req   = (state == acpi_pkg::READ);
	assign win_valid = (state == acpi_pkg::EMIT);
	assign last_pix  = (row == acpi_pkg::ADDR_W'(IMG_H - 1)) &&
	                   (col == acpi_pkg::ADDR_W'(IMG_W - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state      <= acpi_pkg::IDLE;
			tap        <= acpi_pkg::CENTER;
			row        <= '0;
			col        <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				acpi_pkg::IDLE: begin
					if (start) begin
						row   <= '0;
						col   <= '0;
						tap   <= acpi_pkg::CENTER;
						state <= acpi_pkg::READ;
					end
				end
				acpi_pkg::READ: begin
					if (img_ready) begin   // Hold the request through a stall
						if (tap == acpi_pkg::D2) begin
							state <= acpi_pkg::EMIT;
						end else begin
							tap <= acpi_pkg::tap_e'(tap + 4'd1);
						end
					end
				end
				acpi_pkg::EMIT: begin
					tap <= acpi_pkg::CENTER;
					if (last_pix) begin
						state      <= acpi_pkg::IDLE;
						frame_done <= 1'b1;
					end else begin
						state <= acpi_pkg::READ;
						if (col == acpi_pkg::ADDR_W'(IMG_W - 1)) begin
							col <= '0;
							row <= row + 1'b1;
						end else begin
							col <= col + 1'b1;
						end
					end
				end
				default: state <= acpi_pkg::IDLE;
			endcase
		end
	end

	// Nine accepted reads leave the center in slot 0
	always_ff @(posedge clk) begin
		if (img_req && img_ready) begin
			for (int i = 0; i < 8; i++) begin
				taps[i] <= taps[i+1];
			end
			taps[8] <= img_data;
		end
	end

	assign win_row = row;
	assign win_col = col;
	assign win_c   = taps[acpi_pkg::CENTER];
	assign win_l1  = taps[acpi_pkg::L1];
	assign win_l2  = taps[acpi_pkg::L2];
	assign win_r1  = taps[acpi_pkg::R1];
	assign win_r2  = taps[acpi_pkg::R2];
	assign win_u1  = taps[acpi_pkg::U1];
	assign win_u2  = taps[acpi_pkg::U2];
	assign win_d1  = taps[acpi_pkg::D1];
	assign win_d2  = taps[acpi_pkg::D2];

endmodule
